//--- verif/ap_fetch_trace.txt
# P addr opcode cam operand mem | S start_addr | L load_count at halt
# E pc opcode cam operand mem illegal (all values hex)
P 0 9 12 1 0100
P 1 4 05 0 0040
P 2 3 33 2 beef
P 3 2 00 0 0000
P 1e 7 1e 2 2000
P 1f f ff 3 ffff
P 20 b 40 3 0005
P 21 2 00 0 0000
P 7e 8 7e 1 1234
P 7f c 7f 2 4321
S 0
E 0 9 12 1 0100 0
E 1 4 05 0 0040 1
E 2 3 33 2 beef 1
E 3 2 00 0 0000 0
L 1
S 2
E 2 3 33 2 beef 1
E 3 2 00 0 0000 0
L 1
S 1e
E 1e 7 1e 2 2000 0
E 1f f ff 3 ffff 1
E 20 b 40 3 0005 0
E 21 2 00 0 0000 0
L 2
S 7e
E 7e 8 7e 1 1234 0
E 7f c 7f 2 4321 0
L 3
S c8
E c8 0 00 0 0000 1
L 3

//--- ap_fetch_top.f
common/ap_pkg.sv
logic/pc_sequencer.sv
ins_cache/ins_cache.sv
logic/ins_decoder.sv
logic/ap_fetch_top.sv
verif/burst_mem_model.sv
verif/ap_fetch_tb.sv

//--- Bender.yml
package:
  name: ap_fetch

sources:
  - common/ap_pkg.sv
  - logic/pc_sequencer.sv
  - ins_cache/ins_cache.sv
  - logic/ins_decoder.sv
  - logic/ap_fetch_top.sv
  - target: test
    files:
      - verif/burst_mem_model.sv
      - verif/ap_fetch_tb.sv

//--- verif/ap_fetch_tb.sv
`timescale 1ns/10ps

module ap_fetch_tb;

    typedef struct packed {
        logic [7:0]                kind;
        logic [ap_pkg::ADDR_W-1:0] value;
        ap_pkg::decoded_t          dec;
    } step_t;

    logic                          clk;
    logic                          rst;
    logic                          start;
    logic [ap_pkg::ADDR_W-1:0]     start_addr;
    logic                          halted;
    logic                          dec_valid;
    ap_pkg::decoded_t              dec_out;
    logic                          rd_req;
    logic                          rd_req_q;
    logic [ap_pkg::MEM_ADDR_W-1:0] rd_addr;
    logic [ap_pkg::CNT_W-1:0]      rd_len;
    logic                          rd_beat_valid;
    logic [ap_pkg::CNT_W-1:0]      rd_cnt;
    ap_pkg::instr_t                rd_word;
    logic [ap_pkg::CNT_W-1:0]      load_count;
    logic [ap_pkg::CNT_W-1:0]      refills;
    logic [ap_pkg::ADDR_W-1:0]     exp_pc;
    step_t                         steps[$];
    int                            errors, cycles, limit, dec_seen;

    ap_fetch_top i_ap_fetch_top (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .start_addr    (start_addr),
        .halted        (halted),
        .dec_valid     (dec_valid),
        .dec_out       (dec_out),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_len        (rd_len),
        .rd_beat_valid (rd_beat_valid),
        .rd_cnt        (rd_cnt),
        .rd_word       (rd_word),
        .load_count    (load_count)
    );

    burst_mem_model i_burst_mem_model (
        .clk           (clk),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_len        (rd_len),
        .rd_beat_valid (rd_beat_valid),
        .rd_cnt        (rd_cnt),
        .rd_word       (rd_word)
    );

    // window length from the refill rule
    function automatic logic [ap_pkg::CNT_W-1:0] refill_len(input logic [ap_pkg::ADDR_W-1:0] pc);
        int left;
        left = ap_pkg::PROG_DEPTH - int'(pc);
        return ap_pkg::CNT_W'((left < ap_pkg::CACHE_DEPTH) ? left : ap_pkg::CACHE_DEPTH);
    endfunction

    task automatic check_decoded(input ap_pkg::decoded_t got, input ap_pkg::decoded_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %0t dec_out got %h expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input logic [ap_pkg::CNT_W-1:0] got,
                               input logic [ap_pkg::CNT_W-1:0] exp, input string name);
        if (got !== exp)
        begin
            $display("MISMATCH %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input logic [ap_pkg::MEM_ADDR_W-1:0] got,
                              input logic [ap_pkg::MEM_ADDR_W-1:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %0t rd_addr got %h expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp)
        begin
            $display("MISMATCH %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // burst checks, decode count and run limit
    always @(posedge clk)
    begin
        cycles   <= cycles + 1;
        rd_req_q <= rd_req;
        if (dec_valid)
            dec_seen <= dec_seen + 1;
        if (rd_req && !rd_req_q)
        begin
            refills <= refills + 1'b1;
            check_addr(rd_addr, ap_pkg::MEM_ADDR_W'(exp_pc) * 8);
            check_count(rd_len, refill_len(exp_pc), "rd_len");
        end
        if (cycles >= limit)
        begin
            $display("timeout after %0d cycles, DUT stopped answering", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial
    begin
        int             fd, a, op, cam, opnd, mem_a, ill;
        int             n_words, n_e, e_done, err_base, pass_cnt, fail_cnt;
        string          line;
        logic [7:0]     kind;
        step_t          st;
        ap_pkg::instr_t w;
        rst        = 1'b0;
        start      = 1'b0;
        start_addr = '0;
        rd_req_q   = 1'b0;
        refills    = '0;
        exp_pc     = '0;
        i_burst_mem_model.fill_pattern();
        fd = $fopen("verif/ap_fetch_trace.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open verif/ap_fetch_trace.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd))
        begin
            kind = 8'h0;
            line = "";
            void'($fgets(line, fd));
            void'($sscanf(line, "%c %h %h %h %h %h %h", kind, a, op, cam, opnd, mem_a, ill));
            st = '{kind, 16'(a), '{ap_pkg::opcode_e'(op), 8'(cam), ap_pkg::operand_e'(opnd),
                                   16'(mem_a), 1'(ill), 16'(a)}};
            if (kind == "P")
            begin
                w = '{4'(op), 8'(cam), 2'(opnd), 16'(mem_a)};
                i_burst_mem_model.load_word(a, w);
                n_words++;
            end
            else if (kind == "S" || kind == "E" || kind == "L")
            begin
                steps.push_back(st);
                if (kind == "E")
                    n_e++;
            end
        end
        if (fd != 0)
            $fclose(fd);
        limit = 40 * (n_e + n_words);

        repeat (8) @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        if (!halted || dec_seen != 0 || refills != 0)
        begin
            $display("activity before start: halted %b, %0d decodes, %0d bursts",
                     halted, dec_seen, refills);
            errors++;
        end

        foreach (steps[i])
        begin
            st = steps[i];
            if (st.kind == "S")
            begin
                err_base = errors;
                @(posedge clk);
                start      <= 1'b1;
                start_addr <= st.value;
                @(posedge clk);
                start <= 1'b0;
            end
            else if (st.kind == "E")
            begin
                exp_pc = st.dec.pc;
                do @(posedge clk); while (!dec_valid);
                check_decoded(dec_out, st.dec);
                check_flag(halted, 1'b0, "halted");
                e_done++;
            end
            else
            begin
                // halted rises on the edge that takes the final decode
                @(posedge clk);
                check_flag(halted, 1'b1, "halted");
                repeat (3) @(posedge clk);
                if (dec_seen != e_done)
                begin
                    $display("%0d decodes seen after halt, %0d expected", dec_seen, e_done);
                    errors++;
                end
                check_count(load_count, ap_pkg::CNT_W'(st.value), "load_count");
                check_count(refills, ap_pkg::CNT_W'(st.value), "refill bursts");
                if (errors == err_base)
                    pass_cnt++;
                else
                    fail_cnt++;
                $display("test %0d start %0h: %s", pass_cnt + fail_cnt, start_addr,
                         (errors == err_base) ? "ok" : "failed");
            end
        end

        if (steps.size() == 0)
        begin
            $display("no test records found in the trace");
            errors++;
        end
        $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- verif/burst_mem_model.sv
`timescale 1ns/10ps

module burst_mem_model
(
    input  logic                          clk,
    input  logic                          rd_req,
    input  logic [ap_pkg::MEM_ADDR_W-1:0] rd_addr,
    input  logic [ap_pkg::CNT_W-1:0]      rd_len,
    output logic                          rd_beat_valid,
    output logic [ap_pkg::CNT_W-1:0]      rd_cnt,
    output ap_pkg::instr_t                rd_word
);

    ap_pkg::instr_t mem [ap_pkg::PROG_DEPTH];

    // background words tagged with their own address
    task automatic fill_pattern();
        for (int a = 0; a < ap_pkg::PROG_DEPTH; a++)
        begin
            mem[a] = '{4'hc, 8'(a), 2'(a), 16'(a * 3 + 1)};
        end
    endtask

    task automatic load_word(input int addr, input ap_pkg::instr_t word);
        mem[addr] = word;
    endtask

    initial
    begin
        int base;
        int len;
        int gap;
        void'($urandom(32'h2df5));
        rd_beat_valid = 1'b0;
        rd_cnt        = '0;
        rd_word       = '0;
        forever
        begin
            @(posedge clk);
            if (rd_req)
            begin
                // byte address back to word index
                base = int'(rd_addr / 8);
                len  = int'(rd_len);
                for (int i = 1; i <= len; i++)
                begin
                    rd_beat_valid <= 1'b1;
                    rd_cnt        <= ap_pkg::CNT_W'(i);
                    rd_word       <= mem[base + i - 1];
                    @(posedge clk);
                    rd_beat_valid <= 1'b0;
                    gap = $urandom % 4;
                    repeat (gap) @(posedge clk);
                end
            end
        end
    end

endmodule

//--- logic/ap_fetch_top.sv
`timescale 1ns/10ps

module ap_fetch_top
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [ap_pkg::ADDR_W-1:0]     start_addr,
    output logic                          halted,
    output logic                          dec_valid,
    output ap_pkg::decoded_t              dec_out,
    output logic                          rd_req,
    output logic [ap_pkg::MEM_ADDR_W-1:0] rd_addr,
    output logic [ap_pkg::CNT_W-1:0]      rd_len,
    input  logic                          rd_beat_valid,
    input  logic [ap_pkg::CNT_W-1:0]      rd_cnt,
    input  ap_pkg::instr_t                rd_word,
    output logic [ap_pkg::CNT_W-1:0]      load_count
);

    logic                      fetch_req;
    logic [ap_pkg::ADDR_W-1:0] fetch_addr;
    logic                      ins_valid;
    ap_pkg::instr_t            ins_word;
    logic                      ret_seen;

    pc_sequencer i_pc_sequencer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .start_addr (start_addr),
        .dec_valid  (dec_valid),
        .ret_seen   (ret_seen),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .halted     (halted)
    );

    ins_cache i_ins_cache (
        .clk           (clk),
        .rst           (rst),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .ins_valid     (ins_valid),
        .ins_word      (ins_word),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_len        (rd_len),
        .rd_beat_valid (rd_beat_valid),
        .rd_cnt        (rd_cnt),
        .rd_word       (rd_word),
        .load_count    (load_count)
    );

    // fetch_addr is held until decode, so it tags the decoded word
    ins_decoder i_ins_decoder (
        .clk       (clk),
        .rst       (rst),
        .ins_valid (ins_valid),
        .ins_word  (ins_word),
        .pc        (fetch_addr),
        .dec_valid (dec_valid),
        .dec_out   (dec_out),
        .ret_seen  (ret_seen)
    );

endmodule

//--- logic/ins_decoder.sv
`timescale 1ns/10ps

module ins_decoder
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ins_valid,
    input  ap_pkg::instr_t            ins_word,
    input  logic [ap_pkg::ADDR_W-1:0] pc,
    output logic                      dec_valid,
    output ap_pkg::decoded_t          dec_out,
    output logic                      ret_seen
);

    ap_pkg::opcode_e  op;
    ap_pkg::operand_e opnd;
    logic             unknown_op;
    logic             mem_class;
    logic             illegal;

    assign op   = ap_pkg::opcode_e'(ins_word.opcode);
    assign opnd = ap_pkg::operand_e'(ins_word.operand);

    always_comb
    begin
        unknown_op = 1'b0;
        mem_class  = 1'b0;
        case (op)
            ap_pkg::RESET, ap_pkg::RET, ap_pkg::COPY, ap_pkg::ADD,
            ap_pkg::SUB, ap_pkg::TSC, ap_pkg::ABS:
            begin
                mem_class = 1'b0;
            end
            ap_pkg::LOADRBR, ap_pkg::LOADCBC, ap_pkg::STORERBR, ap_pkg::STORECBC:
            begin
                mem_class = 1'b1;
            end
            default: unknown_op = 1'b1;
        endcase
    end

    // memory transfers need a source or destination operand
    assign illegal = unknown_op || (mem_class && opnd == ap_pkg::NONE);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            dec_valid <= 1'b0;
            ret_seen  <= 1'b0;
        end
        else
        begin
            dec_valid <= ins_valid;
            ret_seen  <= ins_valid && (op == ap_pkg::RET);
        end
    end

    always_ff @(posedge clk)
    begin
        if (ins_valid)
        begin
            dec_out.opcode   <= op;
            dec_out.cam_addr <= ins_word.cam_addr;
            dec_out.operand  <= opnd;
            dec_out.mem_addr <= ins_word.mem_addr;
            dec_out.illegal  <= illegal;
            dec_out.pc       <= pc;
        end
    end

endmodule

//--- ins_cache/ins_cache.sv
`timescale 1ns/10ps

module ins_cache
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_req,
    input  logic [ap_pkg::ADDR_W-1:0]     fetch_addr,
    output logic                          ins_valid,
    output ap_pkg::instr_t                ins_word,
    output logic                          rd_req,
    output logic [ap_pkg::MEM_ADDR_W-1:0] rd_addr,
    output logic [ap_pkg::CNT_W-1:0]      rd_len,
    input  logic                          rd_beat_valid,
    input  logic [ap_pkg::CNT_W-1:0]      rd_cnt,
    input  ap_pkg::instr_t                rd_word,
    output logic [ap_pkg::CNT_W-1:0]      load_count
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        SERVE
    } state_e;

    state_e                    state;
    ap_pkg::instr_t            cache_mem [ap_pkg::CACHE_DEPTH];
    logic [ap_pkg::ADDR_W-1:0] win_base;
    logic [ap_pkg::CNT_W-1:0]  win_len;
    logic                      win_valid;
    logic [ap_pkg::ADDR_W-1:0] offset;
    logic [ap_pkg::ADDR_W-1:0] remain;
    logic [ap_pkg::CNT_W-1:0]  beat_num;
    logic                      out_of_range;
    logic                      hit;
    logic                      last_beat;

    assign offset       = fetch_addr - win_base;
    assign out_of_range = (fetch_addr >= ap_pkg::ADDR_W'(ap_pkg::PROG_DEPTH));
    assign hit          = win_valid && (offset < ap_pkg::ADDR_W'(win_len));

    // tail window near the end of the program is shorter
    assign remain = ap_pkg::ADDR_W'(ap_pkg::PROG_DEPTH) - fetch_addr;
    assign rd_len = (remain > ap_pkg::ADDR_W'(ap_pkg::CACHE_DEPTH))
                  ? ap_pkg::CNT_W'(ap_pkg::CACHE_DEPTH)
                  : ap_pkg::CNT_W'(remain);

    // word address to byte address
    assign rd_addr = ap_pkg::MEM_ADDR_W'(fetch_addr) << ap_pkg::WORD_BYTES_LOG2;

    assign rd_req    = (state == LOOKUP && !out_of_range && !hit) || (state == REFILL);
    assign last_beat = (state == REFILL) && rd_beat_valid && (rd_cnt == rd_len);
    assign beat_num  = rd_cnt - 1'b1;

    // hits and illegal addresses answer straight from lookup
    assign ins_valid = (state == LOOKUP && (out_of_range || hit)) || (state == SERVE);
    assign ins_word  = out_of_range ? '0 : cache_mem[offset[ap_pkg::CACHE_AW-1:0]];

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state      <= IDLE;
            win_base   <= '0;
            win_len    <= '0;
            win_valid  <= 1'b0;
            load_count <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (fetch_req)
                    begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP:
                begin
                    if (out_of_range || hit)
                    begin
                        state <= IDLE;
                    end
                    else
                    begin
                        // window is rebased on the missing address
                        win_base  <= fetch_addr;
                        win_valid <= 1'b0;
                        state     <= REFILL;
                    end
                end
                REFILL:
                begin
                    if (last_beat)
                    begin
                        win_len    <= rd_len;
                        win_valid  <= 1'b1;
                        load_count <= load_count + 1'b1;
                        state      <= SERVE;
                    end
                end
                SERVE:
                begin
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == REFILL && rd_beat_valid)
        begin
            cache_mem[beat_num[ap_pkg::CACHE_AW-1:0]] <= rd_word;
        end
    end

    // burst request stays up until the final beat
    a_rd_req_hold: assert property (@(posedge clk) disable iff (!rst)
        (rd_req && !last_beat) |=> rd_req);

    a_rd_cnt_bound: assert property (@(posedge clk) disable iff (!rst)
        rd_beat_valid |-> (rd_cnt != '0 && rd_cnt <= rd_len));

    // sequencer only asks when the cache is idle
    a_fetch_when_idle: assert property (@(posedge clk) disable iff (!rst)
        fetch_req |-> (state == IDLE));

endmodule

//--- logic/pc_sequencer.sv
`timescale 1ns/10ps

module pc_sequencer
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [ap_pkg::ADDR_W-1:0] start_addr,
    input  logic                      dec_valid,
    input  logic                      ret_seen,
    output logic                      fetch_req,
    output logic [ap_pkg::ADDR_W-1:0] fetch_addr,
    output logic                      halted
);

    typedef enum logic {
        IDLE,
        WAIT
    } state_e;

    state_e                    state;
    logic [ap_pkg::ADDR_W-1:0] pc;
    logic                      last_word;

    // next pc would fall outside the program
    assign last_word  = (pc >= ap_pkg::ADDR_W'(ap_pkg::PROG_DEPTH - 1));
    assign fetch_addr = pc;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state     <= IDLE;
            pc        <= '0;
            fetch_req <= 1'b0;
            halted    <= 1'b1;
        end
        else
        begin
            fetch_req <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        pc        <= start_addr;
                        halted    <= 1'b0;
                        fetch_req <= 1'b1;
                        state     <= WAIT;
                    end
                end
                WAIT:
                begin
                    if (dec_valid)
                    begin
                        if (ret_seen || last_word)
                        begin
                            halted <= 1'b1;
                            state  <= IDLE;
                        end
                        else
                        begin
                            pc        <= pc + 1'b1;
                            fetch_req <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_no_fetch_when_halted: assert property (@(posedge clk) disable iff (!rst)
        fetch_req |-> !halted);

endmodule

//--- common/ap_pkg.sv
package ap_pkg;

    // address and memory widths
    localparam int ADDR_W          = 16;
    localparam int MEM_ADDR_W      = 28;
    localparam int WORD_BYTES_LOG2 = 3;

    // program image and cache window
    localparam int PROG_DEPTH      = 128;
    localparam int CACHE_DEPTH     = 32;
    localparam int CACHE_AW        = $clog2(CACHE_DEPTH);

    // burst length and beat counter
    localparam int CNT_W           = 10;

    // instruction field widths
    localparam int OPCODE_W        = 4;
    localparam int CAM_W           = 8;
    localparam int OPERAND_W       = 2;
    localparam int MEM_W           = 16;

    typedef enum logic [OPCODE_W-1:0] {
        RESET    = 4'd1,
        RET      = 4'd2,
        LOADRBR  = 4'd4,
        LOADCBC  = 4'd5,
        STORERBR = 4'd6,
        STORECBC = 4'd7,
        COPY     = 4'd8,
        ADD      = 4'd9,
        SUB      = 4'd10,
        TSC      = 4'd11,
        ABS      = 4'd12
    } opcode_e;

    // operand 2 selector
    typedef enum logic [OPERAND_W-1:0] {
        NONE = 2'd0,
        M_A  = 2'd1,
        M_B  = 2'd2,
        M_R  = 2'd3
    } operand_e;

    // raw program word with an unchecked opcode
    typedef struct packed {
        logic [OPCODE_W-1:0]  opcode;
        logic [CAM_W-1:0]     cam_addr;
        logic [OPERAND_W-1:0] operand;
        logic [MEM_W-1:0]     mem_addr;
    } instr_t;

    typedef struct packed {
        opcode_e              opcode;
        logic [CAM_W-1:0]     cam_addr;
        operand_e             operand;
        logic [MEM_W-1:0]     mem_addr;
        logic                 illegal;
        logic [ADDR_W-1:0]    pc;
    } decoded_t;

endpackage
